// File: tb/fetch_golden.txt
# program: word count in decimal, then the words in hex, four per line.
# cycles: stall flush jump branch jump_addr branch_addr exp_valid exp_pc_plus4 exp_instruction.
# stall 2 marks a line that the testbench may precede with random stall cycles.
16
24010001 24020002 24030003 24040004
24050005 24060006 24070007 24080008
24090009 240a000a 240b000b 240c000c
240d000d 240e000e 240f000f 24100010
0 0 0 0 00000000 00000000 0 00000000 00000000
0 0 0 0 00000000 00000000 1 00000004 24010001
0 0 0 0 00000000 00000000 1 00000008 24020002
0 0 0 0 00000000 00000000 1 0000000c 24030003
1 0 0 0 00000000 00000000 1 0000000c 24030003
1 0 0 0 00000000 00000000 1 0000000c 24030003
0 0 0 0 00000000 00000000 1 00000010 24040004
2 0 0 0 00000000 00000000 1 00000014 24050005
2 0 0 0 00000000 00000000 1 00000018 24060006
0 0 0 1 00000000 00000028 1 0000001c 24070007
0 1 0 0 00000000 00000000 0 00000000 00000000
0 0 0 0 00000000 00000000 1 0000002c 240b000b
0 0 0 0 00000000 00000000 1 00000030 240c000c
0 0 1 1 00000008 00000038 1 00000034 240d000d
0 1 0 0 00000000 00000000 0 00000000 00000000
0 0 0 0 00000000 00000000 1 0000000c 24030003
0 0 0 0 00000000 00000000 1 00000010 24040004
1 1 0 0 00000000 00000000 0 00000000 00000000
0 0 0 0 00000000 00000000 0 00000000 00000000
0 0 0 0 00000000 00000000 1 00000018 24060006
2 0 0 0 00000000 00000000 1 0000001c 24070007
2 0 0 0 00000000 00000000 1 00000020 24080008
0 0 1 0 00000038 00000000 1 00000024 24090009
0 1 0 0 00000000 00000000 0 00000000 00000000
0 0 0 0 00000000 00000000 1 0000003c 240f000f

// File: flist.f
common/fetch_pkg.sv
if_stage/program_counter.sv
if_stage/instruction_memory.sv
if_stage/if_stage.sv
src/program_loader.sv
src/if_id_register.sv
src/fetch_top.sv
tb/tb_fetch_top.sv

// File: tb/tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

    import fetch_pkg::*;

    localparam int FREE_STALL = 2;   // stall code that allows random extra stalls.

    logic      i_clock;
    logic      i_rst;
    logic      i_load_strobe;
    instr_t    i_load_word;
    logic      i_load_end;
    logic      i_stall;
    logic      i_flush;
    redirect_t i_redirect;
    logic      o_load_done;
    if_id_t    o_if_id;

    instr_t    program_words [$];
    int        stall_q [$];
    logic      flush_q [$];
    redirect_t redirect_q [$];
    if_id_t    expect_q [$];
    int        free_count;
    int        cycle_count;
    int        cycle_limit;
    integer    seed;

    fetch_top dut0 (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_load_strobe (i_load_strobe),
        .i_load_word   (i_load_word),
        .i_load_end    (i_load_end),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_redirect    (i_redirect),
        .o_load_done   (o_load_done),
        .o_if_id       (o_if_id)
    );

    always #20 i_clock = ~i_clock;

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        stop_with_failure();
    endtask

    always @(posedge i_clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            report_error($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    task automatic read_golden();
        int          fd;
        int          n;
        int          word_total;
        string       line;
        logic [31:0] w [4];
        logic [31:0] s, f, j, b, ja, ba, v, p4, ins;
        fd = $fopen("tb/fetch_golden.txt", "r");
        word_total = -1;
        if (fd == 0) begin
            report_error("cannot open golden file tb/fetch_golden.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                if (word_total < 0) begin
                    n = $sscanf(line, "%d", word_total);
                end else if (program_words.size() < word_total) begin
                    n = $sscanf(line, "%h %h %h %h", w[0], w[1], w[2], w[3]);
                    for (int i = 0; i < n; i++) begin
                        program_words.push_back(w[i]);
                    end
                end else begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                s, f, j, b, ja, ba, v, p4, ins);
                    if (n == 9) begin
                        stall_q.push_back(int'(s));
                        flush_q.push_back(f[0]);
                        redirect_q.push_back('{jump: j[0], branch: b[0],
                                               jump_address: ja, branch_address: ba});
                        expect_q.push_back('{valid: v[0], pc_plus4: p4, instruction: ins});
                        if (s == FREE_STALL) begin
                            free_count++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        i_rst         = 1'b1;
        i_load_strobe = 1'b0;
        i_load_end    = 1'b0;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_redirect    = '0;
        repeat (5) @(negedge i_clock);
        i_rst = 1'b0;
        assert (!o_if_id.valid && !o_load_done)
        else report_mismatch("if_id valid or load done high after reset");
    endtask

    task automatic load_program();
        int waited;
        foreach (program_words[k]) begin
            i_load_strobe = 1'b1;
            i_load_word   = program_words[k];
            @(negedge i_clock);
            assert (!o_if_id.valid && !o_load_done)
            else report_mismatch($sformatf("valid or done high while loading word %0d", k));
        end
        i_load_strobe = 1'b0;
        i_load_end    = 1'b1;
        @(negedge i_clock);
        i_load_end = 1'b0;
        waited     = 0;
        while (!o_load_done && waited < 4) begin
            @(negedge i_clock);
            waited++;
        end
        assert (o_load_done)
        else report_error("load done did not rise after the end-of-load strobe");
    endtask

    task automatic check_if_id(input int c, input if_id_t expected);
        logic match;
        match = (o_if_id.valid === expected.valid);
        if (expected.valid) begin
            match = match && (o_if_id.pc_plus4 === expected.pc_plus4)
                          && (o_if_id.instruction === expected.instruction);
        end
        assert (match)
        else report_mismatch($sformatf("cycle %0d expected %0b %h %h, got %0b %h %h", c,
            expected.valid, expected.pc_plus4, expected.instruction,
            o_if_id.valid, o_if_id.pc_plus4, o_if_id.instruction));
    endtask

    // free lines may be preceded by random stalls, which must hold if_id.
    task automatic replay();
        if_id_t held;
        int     extra;
        for (int c = 0; c < stall_q.size(); c++) begin
            if (stall_q[c] == FREE_STALL) begin
                extra = $unsigned($random(seed)) % 4;
                repeat (extra) begin
                    held       = o_if_id;
                    i_stall    = 1'b1;
                    i_flush    = 1'b0;
                    i_redirect = '0;
                    @(negedge i_clock);
                    assert (o_if_id === held)
                    else report_mismatch($sformatf("cycle %0d if_id moved in a stall", c));
                end
            end
            i_stall    = (stall_q[c] == 1);
            i_flush    = flush_q[c];
            i_redirect = redirect_q[c];
            @(negedge i_clock);
            check_if_id(c, expect_q[c]);
        end
        i_stall    = 1'b0;
        i_flush    = 1'b0;
        i_redirect = '0;
    endtask

    initial begin
        i_clock       = 1'b0;
        i_rst         = 1'b1;
        i_load_strobe = 1'b0;
        i_load_word   = '0;
        i_load_end    = 1'b0;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_redirect    = '0;
        seed          = 32'h5c0bd1b7;
        free_count    = 0;
        cycle_count   = 0;
        cycle_limit   = 1000;
        read_golden();
        // two passes, the second starts with a reset in the middle of fetch.
        cycle_limit = 2 * (5 + program_words.size() + 6 + stall_q.size() + 3 * free_count) + 50;
        repeat (2) begin
            apply_reset();
            load_program();
            replay();
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                 i_clock,
    input  logic                 i_rst,
    input  logic                 i_load_strobe,
    input  fetch_pkg::instr_t    i_load_word,
    input  logic                 i_load_end,
    input  logic                 i_stall,
    input  logic                 i_flush,
    input  fetch_pkg::redirect_t i_redirect,
    output logic                 o_load_done,
    output fetch_pkg::if_id_t    o_if_id
);

    import fetch_pkg::*;

    imem_wr_t    load_wr;
    logic        load_done;
    fetch_word_t fetch_word;
    logic        fetch_valid;

    program_loader program_loader_1 (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_load_strobe (i_load_strobe),
        .i_load_word   (i_load_word),
        .i_load_end    (i_load_end),
        .o_wr          (load_wr),
        .o_load_done   (load_done)
    );

    // fetch runs only after the program is in memory.
    if_stage if_stage_1 (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_run         (load_done),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_redirect    (i_redirect),
        .i_wr          (load_wr),
        .o_fetch       (fetch_word),
        .o_fetch_valid (fetch_valid)
    );

    if_id_register if_id_register_1 (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_fetch       (fetch_word),
        .i_fetch_valid (fetch_valid),
        .o_if_id       (o_if_id)
    );

    assign o_load_done = load_done;

endmodule

`default_nettype wire

// File: src/if_id_register.sv
`timescale 1ns/1ps
`default_nettype none

module if_id_register (
    input  logic                   i_clock,
    input  logic                   i_rst,
    input  logic                   i_stall,
    input  logic                   i_flush,
    input  fetch_pkg::fetch_word_t i_fetch,
    input  logic                   i_fetch_valid,
    output fetch_pkg::if_id_t      o_if_id
);

    import fetch_pkg::*;

    fetch_word_t word_q;
    logic        valid_q;

    always_ff @(posedge i_clock) begin
        if (!i_stall) begin
            word_q <= i_fetch;
        end
    end

    // flush beats stall.
    always_ff @(posedge i_clock) begin
        if (i_rst || i_flush) begin
            valid_q <= 1'b0;
        end else if (!i_stall) begin
            valid_q <= i_fetch_valid;
        end
    end

    assign o_if_id = '{
        valid:       valid_q,
        pc_plus4:    word_q.pc_plus4,
        instruction: word_q.instruction
    };

endmodule

`default_nettype wire

// File: src/program_loader.sv
`timescale 1ns/1ps
`default_nettype none

module program_loader (
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_load_strobe,
    input  fetch_pkg::instr_t   i_load_word,
    input  logic                i_load_end,
    output fetch_pkg::imem_wr_t o_wr,
    output logic                o_load_done
);

    import fetch_pkg::*;

    load_state_t state;
    load_state_t state_next;
    imem_addr_t  word_count;
    logic        write;
    logic        last_word;

    assign write     = i_load_strobe && (state == LOAD_FILL);
    assign last_word = write && (word_count == imem_addr_t'(IMEM_DEPTH - 1));

    always_comb begin
        state_next = state;
        case (state)
            LOAD_FILL: begin
                if (i_load_end || last_word) begin
                    state_next = LOAD_DONE;
                end
            end
            LOAD_DONE: state_next = LOAD_DONE;   // only reset leaves.
            default:   state_next = LOAD_FILL;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state      <= LOAD_FILL;
            word_count <= '0;
        end else begin
            state <= state_next;
            if (write) begin
                word_count <= word_count + 1'b1;   // wraps on the last word, state is done by then.
            end
        end
    end

    assign o_wr        = '{we: write, addr: word_count, data: i_load_word};
    assign o_load_done = (state == LOAD_DONE);

endmodule

`default_nettype wire

// File: if_stage/if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage (
    input  logic                   i_clock,
    input  logic                   i_rst,
    input  logic                   i_run,
    input  logic                   i_stall,
    input  logic                   i_flush,
    input  fetch_pkg::redirect_t   i_redirect,
    input  fetch_pkg::imem_wr_t    i_wr,
    output fetch_pkg::fetch_word_t o_fetch,
    output logic                   o_fetch_valid
);

    import fetch_pkg::*;

    logic       advance;
    pc_t        pc;
    pc_t        pc_plus4;
    pc_t        pc_plus4_q;
    imem_addr_t read_addr;
    instr_t     instruction;
    logic       valid_q;

    assign advance   = i_run && !i_stall;          // gates both pc and memory.
    assign read_addr = pc[IMEM_ADDR_BITS+1:2];     // byte address to word index.

    program_counter program_counter_1 (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_advance  (advance),
        .i_redirect (i_redirect),
        .o_pc       (pc),
        .o_pc_plus4 (pc_plus4)
    );

    instruction_memory instruction_memory_1 (
        .i_clock       (i_clock),
        .i_wr          (i_wr),
        .i_read_enable (advance),
        .i_read_addr   (read_addr),
        .o_read_data   (instruction)
    );

    // pc+4 follows the memory read so each word carries its own pc+4.
    always_ff @(posedge i_clock) begin
        if (advance) begin
            pc_plus4_q <= pc_plus4;
        end
    end

    // a new fetch replaces the pending word, so flush only clears a held one.
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= 1'b1;
        end else if (i_flush) begin
            valid_q <= 1'b0;
        end
    end

    assign o_fetch       = '{pc_plus4: pc_plus4_q, instruction: instruction};
    assign o_fetch_valid = valid_q;

endmodule

`default_nettype wire

// File: if_stage/instruction_memory.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_memory (
    input  logic                  i_clock,
    input  fetch_pkg::imem_wr_t   i_wr,
    input  logic                  i_read_enable,
    input  fetch_pkg::imem_addr_t i_read_addr,
    output fetch_pkg::instr_t     o_read_data
);

    import fetch_pkg::*;

    instr_t mem [IMEM_DEPTH];
    instr_t read_data;

    // write port, fed by the loader.
    always_ff @(posedge i_clock) begin
        if (i_wr.we) begin
            mem[i_wr.addr] <= i_wr.data;
        end
    end

    // registered read port, holds its word while disabled.
    always_ff @(posedge i_clock) begin
        if (i_read_enable) begin
            read_data <= mem[i_read_addr];
        end
    end

    assign o_read_data = read_data;

    // loading and fetching never overlap. fetch only starts once the loader is done.
    a_no_write_during_read: assert property (@(posedge i_clock)
        !(i_wr.we && i_read_enable))
        else $error("imem write at %0d while fetch is reading", i_wr.addr);

endmodule

`default_nettype wire

// File: if_stage/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter (
    input  logic                 i_clock,
    input  logic                 i_rst,
    input  logic                 i_advance,
    input  fetch_pkg::redirect_t i_redirect,
    output fetch_pkg::pc_t       o_pc,
    output fetch_pkg::pc_t       o_pc_plus4
);

    import fetch_pkg::*;

    pc_t pc;
    pc_t pc_plus4;
    pc_t pc_next;

    assign pc_plus4 = pc + pc_t'(PC_STEP);

    // jump wins over branch.
    always_comb begin
        if (i_redirect.jump) begin
            pc_next = i_redirect.jump_address;
        end else if (i_redirect.branch) begin
            pc_next = i_redirect.branch_address;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            pc <= '0;
        end else if (i_advance) begin
            pc <= pc_next;
        end
    end

    assign o_pc       = pc;
    assign o_pc_plus4 = pc_plus4;

    // redirect targets come from outside, so alignment is not guaranteed here.
    a_pc_aligned: assert property (@(posedge i_clock) disable iff (i_rst)
        pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// File: common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int NB_PC          = 32;
    localparam int NB_INSTRUCTION = 32;
    localparam int PC_STEP        = 4;   // bytes between sequential instructions.
    localparam int IMEM_DEPTH     = 64;
    localparam int IMEM_ADDR_BITS = 6;

    typedef logic [NB_PC-1:0]          pc_t;
    typedef logic [NB_INSTRUCTION-1:0] instr_t;
    typedef logic [IMEM_ADDR_BITS-1:0] imem_addr_t;

    // next-address request from decode/execute.
    typedef struct packed {
        logic jump;
        logic branch;
        pc_t  jump_address;
        pc_t  branch_address;
    } redirect_t;

    typedef struct packed {
        logic       we;
        imem_addr_t addr;
        instr_t     data;
    } imem_wr_t;

    typedef struct packed {
        pc_t    pc_plus4;
        instr_t instruction;
    } fetch_word_t;

    typedef struct packed {
        logic   valid;
        pc_t    pc_plus4;
        instr_t instruction;
    } if_id_t;

    typedef enum logic {
        LOAD_FILL = 1'b0,
        LOAD_DONE = 1'b1
    } load_state_t;

endpackage

`default_nettype wire
